// File: source/intra4_geom_pkg.sv
// Assumes 8-bit luma and row-major 4x4 blocks with pixel 0 in the lowest byte
`default_nettype none

package intra4_geom_pkg;

    // One luma sample
    typedef logic [7:0] pixel_t;

    // Pixel (x, y) sits at index y*4 + x
    typedef pixel_t [15:0] blk4_t;

    // Top neighbours by x, left neighbours by y
    typedef pixel_t [3:0] edge4_t;

    // Mode order also sets the tie rule, lower value wins
    typedef enum logic [1:0] {
        DC = 2'd0,
        TM = 2'd1,
        VE = 2'd2,
        HE = 2'd3
    } mode_t;

    localparam int NUM_MODES = 4;

endpackage

`default_nettype wire

// File: source/intra4_cost_pkg.sv
// Score width holds 256 x SSE plus lambda x cost only for lambda below 2^16
`default_nettype none

package intra4_cost_pkg;

    // Worst case is 16 x 255^2
    localparam int SSE_W = 21;

    typedef logic [31:0] score_t;

    typedef logic [11:0] cost_t;

    // Fixed header cost per mode, DC first
    localparam cost_t MODE_COST [intra4_geom_pkg::NUM_MODES] = '{
        12'd40,
        12'd1151,
        12'd1723,
        12'd1874
    };

endpackage

`default_nettype wire

// File: source/intra4_ifs.sv
// Context data is only valid from its valid pulse up to the next accepted start
`default_nettype none

interface intra4_ctx_if #(
    parameter int LAMBDA_W = 16
);
    logic                    valid;
    intra4_geom_pkg::blk4_t  src;
    intra4_geom_pkg::edge4_t top;
    intra4_geom_pkg::edge4_t left;
    intra4_geom_pkg::pixel_t top_left;
    logic [LAMBDA_W-1:0]     lambda;

    modport source (output valid, src, top, left, top_left, lambda);
    modport sink   (input  valid, src, top, left, top_left, lambda);
endinterface

// No ready on this bus, the consumer takes one result per cycle
interface intra4_res_if;
    logic                          valid;
    logic                          last;
    intra4_geom_pkg::mode_t        mode;
    intra4_cost_pkg::score_t       score;
    intra4_geom_pkg::blk4_t        pred;

    modport source (output valid, last, mode, score, pred);
    modport sink   (input  valid, last, mode, score, pred);
endinterface

`default_nettype wire

// File: source/intra4_ctx_capture.sv
// Starts that arrive while busy are dropped, context is held until the next accepted start
`default_nettype none

module intra4_ctx_capture #(
    parameter int LAMBDA_W = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic                    done_i,
    input  intra4_geom_pkg::blk4_t  src_i,
    input  intra4_geom_pkg::edge4_t top_i,
    input  intra4_geom_pkg::edge4_t left_i,
    input  intra4_geom_pkg::pixel_t top_left_i,
    input  logic [LAMBDA_W-1:0]     lambda_i,
    output logic                    busy_o,
    intra4_ctx_if.source            ctx
);

    logic busy_q;
    logic accept;

    // Busy drops in the done cycle so a new start can follow at once
    assign busy_o = busy_q & ~done_i;
    assign accept = start_i & ~busy_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            ctx.valid <= 1'b0;
        end else begin
            ctx.valid <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ctx.src      <= src_i;
            ctx.top      <= top_i;
            ctx.left     <= left_i;
            ctx.top_left <= top_left_i;
            ctx.lambda   <= lambda_i;
        end
    end

endmodule

`default_nettype wire

// File: source/intra4_predictor.sv
// Plain VE and HE without edge smoothing, no top-right context is used
`default_nettype none

module intra4_predictor (
    input  intra4_geom_pkg::edge4_t top_i,
    input  intra4_geom_pkg::edge4_t left_i,
    input  intra4_geom_pkg::pixel_t top_left_i,
    input  intra4_geom_pkg::mode_t  mode_i,
    output intra4_geom_pkg::blk4_t  pred_o
);

    logic [10:0]             dc_sum;
    intra4_geom_pkg::pixel_t dc_val;

    // Rounded mean of the eight neighbours
    always_comb begin
        dc_sum = 11'd4;
        for (int k = 0; k < 4; k++) begin
            dc_sum = dc_sum + 11'(top_i[k]) + 11'(left_i[k]);
        end
    end

    assign dc_val = dc_sum[10:3];

    always_comb begin : pred_gen
        logic signed [9:0] grad;
        grad = '0;
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                case (mode_i)
                    intra4_geom_pkg::DC: begin
                        pred_o[y*4 + x] = dc_val;
                    end
                    intra4_geom_pkg::TM: begin
                        grad = $signed({2'b00, left_i[y]}) + $signed({2'b00, top_i[x]})
                             - $signed({2'b00, top_left_i});
                        // Clip gradient to the pixel range
                        if (grad < 0) begin
                            pred_o[y*4 + x] = 8'd0;
                        end else if (grad > 10'sd255) begin
                            pred_o[y*4 + x] = 8'd255;
                        end else begin
                            pred_o[y*4 + x] = grad[7:0];
                        end
                    end
                    intra4_geom_pkg::VE: begin
                        pred_o[y*4 + x] = top_i[x];
                    end
                    default: begin
                        pred_o[y*4 + x] = left_i[y];
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/intra4_mode_eval.sv
// Issues DC, TM, VE, HE back to back after each context pulse, two cycles per mode
`default_nettype none

module intra4_mode_eval #(
    parameter int LAMBDA_W = 16
) (
    input  logic          clk,
    input  logic          rst_n,
    intra4_ctx_if.sink    ctx,
    intra4_res_if.source  res
);

    logic [1:0]                           cnt_q;
    logic                                 run_q;
    logic                                 issue;
    intra4_geom_pkg::mode_t               cur_mode;
    intra4_geom_pkg::blk4_t               cur_pred;
    logic [15:0]                          sq_next [16];
    logic                                 s1_valid;
    logic                                 s1_last;
    intra4_geom_pkg::mode_t               s1_mode;
    intra4_geom_pkg::blk4_t               s1_pred;
    logic [15:0]                          s1_sq [16];
    logic [intra4_cost_pkg::SSE_W-1:0]    sse;
    logic [LAMBDA_W-1:0]                  lambda;
    intra4_cost_pkg::score_t              rd_cost;
    intra4_cost_pkg::score_t              score;

    // ------------------------------------------------------------------------
    // Mode issue
    // ------------------------------------------------------------------------
    assign issue    = ctx.valid | run_q;
    assign cur_mode = intra4_geom_pkg::mode_t'(cnt_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= 2'd0;
            run_q <= 1'b0;
        end else if (issue) begin
            // Counter wraps back to DC after HE
            cnt_q <= cnt_q + 2'd1;
            run_q <= (cnt_q != 2'd3);
        end
    end

    intra4_predictor i_intra4_predictor (
        .top_i      (ctx.top),
        .left_i     (ctx.left),
        .top_left_i (ctx.top_left),
        .mode_i     (cur_mode),
        .pred_o     (cur_pred)
    );

    always_comb begin : sq_gen
        logic [7:0] diff;
        diff = '0;
        for (int i = 0; i < 16; i++) begin
            diff = (ctx.src[i] > cur_pred[i]) ? ctx.src[i] - cur_pred[i]
                                              : cur_pred[i] - ctx.src[i];
            sq_next[i] = diff * diff;
        end
    end

    // ------------------------------------------------------------------------
    // Stage 1 and stage 2
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s1_last   <= 1'b0;
            res.valid <= 1'b0;
            res.last  <= 1'b0;
        end else begin
            s1_valid  <= issue;
            s1_last   <= issue & (cnt_q == 2'd3);
            res.valid <= s1_valid;
            res.last  <= s1_valid & s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            s1_mode <= cur_mode;
            s1_pred <= cur_pred;
            s1_sq   <= sq_next;
        end
    end

    always_comb begin
        sse = '0;
        for (int i = 0; i < 16; i++) begin
            sse = sse + intra4_cost_pkg::SSE_W'(s1_sq[i]);
        end
    end

    assign lambda  = ctx.lambda;
    assign rd_cost = intra4_cost_pkg::score_t'(lambda)
                   * intra4_cost_pkg::score_t'(intra4_cost_pkg::MODE_COST[s1_mode]);
    assign score   = (intra4_cost_pkg::score_t'(sse) << 8) + rd_cost;

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            res.mode  <= s1_mode;
            res.score <= score;
            res.pred  <= s1_pred;
        end
    end

endmodule

`default_nettype wire

// File: source/intra4_best_select.sv
// Expects results in mode order starting with DC, outputs hold until the next done
`default_nettype none

module intra4_best_select (
    input  logic                    clk,
    input  logic                    rst_n,
    intra4_res_if.sink              res,
    output intra4_geom_pkg::mode_t  best_mode_o,
    output intra4_cost_pkg::score_t best_score_o,
    output intra4_geom_pkg::blk4_t  best_pred_o,
    output logic                    done_o
);

    logic                    take;
    intra4_geom_pkg::mode_t  run_mode;
    intra4_cost_pkg::score_t run_score;
    intra4_geom_pkg::blk4_t  run_pred;

    // DC seeds the fold, later modes need a strictly lower score
    assign take = (res.mode == intra4_geom_pkg::DC) || (res.score < run_score);

    always_ff @(posedge clk) begin
        if (res.valid && take) begin
            run_mode  <= res.mode;
            run_score <= res.score;
            run_pred  <= res.pred;
        end
    end

    // Final fold goes straight to the outputs with done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_mode_o  <= intra4_geom_pkg::DC;
            best_score_o <= '0;
            best_pred_o  <= '0;
            done_o       <= 1'b0;
        end else begin
            done_o <= res.valid & res.last;
            if (res.valid && res.last) begin
                best_mode_o  <= take ? res.mode  : run_mode;
                best_score_o <= take ? res.score : run_score;
                best_pred_o  <= take ? res.pred  : run_pred;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/intra4_pick_top.sv
// One 4x4 luma block per request, done follows an accepted start by six cycles
`default_nettype none

module intra4_pick_top #(
    parameter int LAMBDA_W = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  intra4_geom_pkg::blk4_t  src_i,
    input  intra4_geom_pkg::edge4_t top_i,
    input  intra4_geom_pkg::edge4_t left_i,
    input  intra4_geom_pkg::pixel_t top_left_i,
    input  logic [LAMBDA_W-1:0]     lambda_i,
    output logic                    busy_o,
    output logic                    done_o,
    output intra4_geom_pkg::mode_t  best_mode_o,
    output intra4_cost_pkg::score_t best_score_o,
    output intra4_geom_pkg::blk4_t  best_pred_o
);

    intra4_ctx_if #(.LAMBDA_W(LAMBDA_W)) ctx_bus ();
    intra4_res_if                        res_bus ();

    intra4_ctx_capture #(.LAMBDA_W(LAMBDA_W)) i_intra4_ctx_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .done_i     (done_o),
        .src_i      (src_i),
        .top_i      (top_i),
        .left_i     (left_i),
        .top_left_i (top_left_i),
        .lambda_i   (lambda_i),
        .busy_o     (busy_o),
        .ctx        (ctx_bus.source)
    );

    intra4_mode_eval #(.LAMBDA_W(LAMBDA_W)) i_intra4_mode_eval (
        .clk   (clk),
        .rst_n (rst_n),
        .ctx   (ctx_bus.sink),
        .res   (res_bus.source)
    );

    intra4_best_select i_intra4_best_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .res          (res_bus.sink),
        .best_mode_o  (best_mode_o),
        .best_score_o (best_score_o),
        .best_pred_o  (best_pred_o),
        .done_o       (done_o)
    );

endmodule

`default_nettype wire

// File: bench/intra4_pick_properties.sv
// Handshake checks sampled on the rising clock edge and disabled while rst_n is low
`default_nettype none

module intra4_pick_properties (
    input logic clk,
    input logic rst_n,
    input logic start_i,
    input logic busy_i,
    input logic done_i
);

    int assert_errors = 0;

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done_i |=> !done_i)
        else begin
            $error("done_o stayed high for two cycles");
            assert_errors++;
        end

    done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
                                      done_i |-> $past(busy_i))
        else begin
            $error("done_o without busy_o in the cycle before");
            assert_errors++;
        end

    // busy_o drops combinationally in the done cycle
    busy_fall: assert property (@(posedge clk) disable iff (!rst_n) $fell(busy_i) |-> done_i)
        else begin
            $error("busy_o fell without done_o");
            assert_errors++;
        end

    busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
                                $rose(busy_i) |-> $past(start_i))
        else begin
            $error("busy_o rose without start_i");
            assert_errors++;
        end

endmodule

bind intra4_pick_top intra4_pick_properties i_intra4_pick_properties (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start_i),
    .busy_i  (busy_o),
    .done_i  (done_o)
);

`default_nettype wire

// File: bench/intra4_pick_tb.sv
// Runs with LAMBDA_W of 16, expects done six cycles after an accepted start
`default_nettype none

module intra4_pick_tb;

    localparam int LAMBDA_W     = 16;
    localparam int NUM_ROWS     = 7;
    localparam int NUM_RANDOM   = 8;
    localparam int DONE_TIMEOUT = 20;

    typedef struct packed {
        intra4_geom_pkg::blk4_t  src;
        intra4_geom_pkg::edge4_t top;
        intra4_geom_pkg::edge4_t left;
        intra4_geom_pkg::pixel_t top_left;
        logic [LAMBDA_W-1:0]     lambda;
        intra4_geom_pkg::mode_t  mode;
    } row_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    start;
    intra4_geom_pkg::blk4_t  src;
    intra4_geom_pkg::edge4_t top;
    intra4_geom_pkg::edge4_t left;
    intra4_geom_pkg::pixel_t top_left;
    logic [LAMBDA_W-1:0]     lambda;
    logic                    busy;
    logic                    done;
    intra4_geom_pkg::mode_t  best_mode;
    intra4_cost_pkg::score_t best_score;
    intra4_geom_pkg::blk4_t  best_pred;

    row_t table_rows [NUM_ROWS];
    row_t rnd_row;
    int   errors = 0;
    int   timeouts = 0;
    int   assert_errors;
    int   mode_rate [4] = '{40, 1151, 1723, 1874};

    always #4 clk = ~clk;

    intra4_pick_top #(.LAMBDA_W(LAMBDA_W)) i_intra4_pick_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .src_i        (src),
        .top_i        (top),
        .left_i       (left),
        .top_left_i   (top_left),
        .lambda_i     (lambda),
        .busy_o       (busy),
        .done_o       (done),
        .best_mode_o  (best_mode),
        .best_score_o (best_score),
        .best_pred_o  (best_pred)
    );

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic intra4_geom_pkg::blk4_t ref_pred(input row_t r, input int m);
        intra4_geom_pkg::blk4_t p;
        int acc;
        int v;
        acc = 4;
        for (int k = 0; k < 4; k++) begin
            acc = acc + int'(r.top[k]) + int'(r.left[k]);
        end
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                case (m)
                    0: v = acc / 8;
                    1: v = int'(r.left[y]) + int'(r.top[x]) - int'(r.top_left);
                    2: v = int'(r.top[x]);
                    default: v = int'(r.left[y]);
                endcase
                v = (v < 0) ? 0 : ((v > 255) ? 255 : v);
                p[y*4 + x] = v[7:0];
            end
        end
        return p;
    endfunction

    function automatic int ref_score(input row_t r, input int m);
        intra4_geom_pkg::blk4_t p;
        int sse;
        int d;
        p = ref_pred(r, m);
        sse = 0;
        for (int i = 0; i < 16; i++) begin
            d = int'(r.src[i]) - int'(p[i]);
            sse = sse + d * d;
        end
        return 256 * sse + int'(r.lambda) * mode_rate[m];
    endfunction

    // Strictly lower score needed, so ties stay with the lower mode
    function automatic int ref_best(input row_t r);
        int best;
        best = 0;
        for (int m = 1; m < 4; m++) begin
            if (ref_score(r, m) < ref_score(r, best)) begin
                best = m;
            end
        end
        return best;
    endfunction

    // ------------------------------------------------------------------------
    // Drive, wait and check
    // ------------------------------------------------------------------------
    task automatic launch(input row_t r);
        @(posedge clk);
        start    <= 1'b1;
        src      <= r.src;
        top      <= r.top;
        left     <= r.left;
        top_left <= r.top_left;
        lambda   <= r.lambda;
        @(posedge clk);
        start    <= 1'b0;
    endtask

    // Counts rising edges after the one the task is entered on
    task automatic wait_done(input int exp_cycles, output bit seen);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        seen = done;
        if (!done) begin
            $display("Timeout: done_o did not rise within %0d cycles", DONE_TIMEOUT);
            timeouts++;
        end else if (cycles != exp_cycles) begin
            $display("** Error at %0t: done after %0d cycles, expected %0d",
                     $time, cycles, exp_cycles);
            errors++;
        end
    endtask

    task automatic check_result(input row_t r, input int exp_mode);
        int exp_score;
        intra4_geom_pkg::blk4_t exp_pred;
        exp_score = ref_score(r, exp_mode);
        exp_pred  = ref_pred(r, exp_mode);
        if (int'(best_mode) != exp_mode) begin
            $display("** Error at %0t: mode %0d, expected %0d", $time, best_mode, exp_mode);
            errors++;
        end
        if (best_score != 32'(exp_score)) begin
            $display("** Error at %0t: score %0d, expected %0d", $time, best_score, exp_score);
            errors++;
        end
        if (best_pred != exp_pred) begin
            $display("** Error at %0t: pred %h, expected %h", $time, best_pred, exp_pred);
            errors++;
        end
    endtask

    task automatic expect_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (done || busy) begin
                $display("** Error at %0t: done %b busy %b while idle", $time, done, busy);
                errors++;
            end
        end
    endtask

    task automatic fill_table();
        // Exact DC, exact TM with clipping, exact VE, exact HE
        table_rows[0] = '{{16{8'h2d}}, 32'h281e140a, 32'h50463c32, 8'd45, 16'd0,
                          intra4_geom_pkg::DC};
        table_rows[1] = '{128'hffffff9b_fffff08c_d2a03c00_a06e0a00, 32'hfac86400,
                          32'hfff03c0a, 8'd100, 16'd0, intra4_geom_pkg::TM};
        table_rows[2] = '{{4{32'hfaaa5a05}}, 32'hfaaa5a05, 32'h3cc8781e, 8'd7, 16'd0,
                          intra4_geom_pkg::VE};
        table_rows[3] = '{128'hebebebeb_afafafaf_5f5f5f5f_0f0f0f0f, 32'h46d28228,
                          32'hebaf5f0f, 8'd9, 16'd0, intra4_geom_pkg::HE};
        // VE source but lambda large enough for DC
        table_rows[4] = table_rows[2];
        table_rows[4].lambda = 16'hffff;
        table_rows[4].mode   = intra4_geom_pkg::DC;
        // TM and VE tie at zero
        table_rows[5] = '{{4{32'h05dc0ac8}}, 32'h05dc0ac8, 32'h1e1e1e1e, 8'd30, 16'd0,
                          intra4_geom_pkg::TM};
        table_rows[6] = table_rows[1];
        table_rows[6].lambda = 16'd100;
    endtask

    initial begin : main
        bit seen;
        void'($urandom(32'ha5fa));
        rst_n    = 1'b0;
        start    = 1'b0;
        src      = '0;
        top      = '0;
        left     = '0;
        top_left = '0;
        lambda   = '0;
        fill_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        expect_idle(4);

        for (int i = 0; i < NUM_ROWS; i++) begin
            launch(table_rows[i]);
            wait_done(6, seen);
            if (seen) begin
                check_result(table_rows[i], int'(table_rows[i].mode));
            end
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd_row.src      = {$urandom(), $urandom(), $urandom(), $urandom()};
            rnd_row.top      = $urandom();
            rnd_row.left     = $urandom();
            rnd_row.top_left = 8'($urandom());
            rnd_row.lambda   = 16'($urandom_range(0, 4095));
            rnd_row.mode     = intra4_geom_pkg::DC;
            launch(rnd_row);
            wait_done(6, seen);
            if (seen) begin
                check_result(rnd_row, ref_best(rnd_row));
            end
        end

        // Second start lands two cycles into the first request
        launch(table_rows[0]);
        launch(table_rows[3]);
        wait_done(4, seen);
        if (seen) begin
            check_result(table_rows[0], int'(table_rows[0].mode));
        end
        expect_idle(8);

        assert_errors = i_intra4_pick_top.i_intra4_pick_properties.assert_errors;
        $display("Check errors: %0d, assertion errors: %0d, timeouts: %0d",
                 errors, assert_errors, timeouts);
        if (errors == 0 && assert_errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
source/intra4_geom_pkg.sv
source/intra4_cost_pkg.sv
source/intra4_ifs.sv
source/intra4_ctx_capture.sv
source/intra4_predictor.sv
source/intra4_mode_eval.sv
source/intra4_best_select.sv
source/intra4_pick_top.sv
bench/intra4_pick_properties.sv
bench/intra4_pick_tb.sv

// File: Bender.yml
package:
  name: intra4_pick

sources:
  - target: any(rtl, test)
    files:
      - source/intra4_geom_pkg.sv
      - source/intra4_cost_pkg.sv
      - source/intra4_ifs.sv
      - source/intra4_ctx_capture.sv
      - source/intra4_predictor.sv
      - source/intra4_mode_eval.sv
      - source/intra4_best_select.sv
      - source/intra4_pick_top.sv
  - target: test
    files:
      - bench/intra4_pick_properties.sv
      - bench/intra4_pick_tb.sv
